// File: design/oflow_defs.svh
`ifndef OFLOW_DEFS_SVH
`define OFLOW_DEFS_SVH

// ---------------------------------------------------------------------------
// frame and score board sizes
// ---------------------------------------------------------------------------
`define NUM_ROWS 8 // boxes per frame
`define ROW_LEN 3 // row index width
`define NUM_PE 4 // candidates per row
`define PE_LEN 2 // pointer width
`define SCORE_LEN 8
`define ID_LEN 6 // 64 look-up entries
`define LUT_DEPTH (1 << `ID_LEN)

// conflict warning level, counter sized to hold it
`define MAX_CONFLICTS_TH 16
`define CONFLICT_CNT_LEN 5

// ---------------------------------------------------------------------------
// apb address map
// ---------------------------------------------------------------------------
`define APB_ADDR_LEN 12
`define APB_DATA_LEN 32
`define REG_CTRL 12'h000 // bit 0 start
`define REG_STATUS 12'h004 // done, conflict limit, busy
`define REG_SCORE_TH 12'h008
`define REG_FIRST_ID 12'h00C
`define CAND_BASE 12'h100 // row * NUM_PE + pe
`define RESULT_BASE 12'h200 // one word per row

`endif

// File: design/oflow_pkg.sv
`include "oflow_defs.svh"

package oflow_pkg;

	// one candidate match from the previous frame
	typedef struct packed {
		logic [`SCORE_LEN-1:0] score;
		logic [`ID_LEN-1:0] id;
	} cand_t;

	// look-up entry, who owns an id and with what score
	typedef struct packed {
		logic [`ROW_LEN-1:0] row;
		logic [`SCORE_LEN-1:0] score;
	} lut_entry_t;

	// resolver access to the score board
	typedef struct packed {
		logic [`ROW_LEN-1:0] row;
		logic [`PE_LEN-1:0] pe; // ram read select
		logic ptr_we;
		logic [`PE_LEN-1:0] ptr;
		logic id_we;
		logic [`ID_LEN-1:0] id;
	} sb_req_t;

	// per row readback at RESULT_BASE
	typedef struct packed {
		logic [`ID_LEN-1:0] id;
		logic [`PE_LEN-1:0] ptr;
	} result_t;

	typedef enum logic [3:0] {
		IDLE,
		FETCH, // present row and pointer to the ram
		WAIT_READ, // candidate arrives
		LOOKUP, // present id to the lut
		DECIDE,
		CLAIM,
		DISPLACE,
		NEXT_ROW,
		DONE
	} cr_state_t;

endpackage

// File: design/oflow_ram.sv
`timescale 1ns/100ps

// behavioural single port ram, registered read
// read during write gives the old word
module oflow_ram #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic [$clog2(DEPTH)-1:0] addr,
	input logic we,
	input T wdata,
	output T rdata
);

	T mem [DEPTH]; // no reset, contents owned by software

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr]; // one cycle latency
	end

endmodule

// File: design/oflow_score_board.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_score_board (
	input logic clk,
	input logic reset_N,
	input logic start,
	input logic busy,
	// apb side, only while idle
	input logic [`ROW_LEN+`PE_LEN-1:0] apb_addr,
	input logic apb_we,
	input oflow_pkg::cand_t apb_wdata,
	output oflow_pkg::cand_t apb_rdata,
	// resolver side, only while busy
	input oflow_pkg::sb_req_t cr_req,
	output oflow_pkg::cand_t cr_cand,
	output logic [`PE_LEN-1:0] cr_ptr,
	// result window
	input logic [`ROW_LEN-1:0] result_row,
	output oflow_pkg::result_t result
);

	logic [`PE_LEN-1:0] ptr_q [`NUM_ROWS]; // next candidate per row
	logic [`ID_LEN-1:0] id_q [`NUM_ROWS]; // assigned id per row
	logic [`ROW_LEN+`PE_LEN-1:0] ram_addr;
	logic ram_we;
	oflow_pkg::cand_t ram_rdata;

	// ram owner follows busy
	assign ram_addr = busy ? {cr_req.row, cr_req.pe} : apb_addr;
	assign ram_we = !busy && apb_we; // resolver never writes candidates

	oflow_ram #(
		.T(oflow_pkg::cand_t),
		.DEPTH(`NUM_ROWS * `NUM_PE)
	) u_cand_ram (
		.clk(clk),
		.addr(ram_addr),
		.we(ram_we),
		.wdata(apb_wdata),
		.rdata(ram_rdata)
	);

	assign apb_rdata = ram_rdata;
	assign cr_cand = ram_rdata;
	assign cr_ptr = ptr_q[cr_req.row]; // combinational pointer of selected row

	assign result.id = id_q[result_row];
	assign result.ptr = ptr_q[result_row];

	// ---------------------------------------------------------------------------
	// per row pointer and id
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			ptr_q <= '{default: '0};
			id_q <= '{default: '0};
		end else if (start) begin
			ptr_q <= '{default: '0}; // every run starts at pe 0
		end else begin
			if (cr_req.ptr_we) begin
				ptr_q[cr_req.row] <= cr_req.ptr;
			end
			if (cr_req.id_we) begin
				id_q[cr_req.row] <= cr_req.id;
			end
		end
	end

endmodule

// File: design/oflow_conflict_resolve_fsm.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_conflict_resolve_fsm (
	input logic clk,
	input logic reset_N,
	input logic start,
	input logic [`SCORE_LEN-1:0] score_th,
	input logic [`ID_LEN-1:0] first_id,
	output logic done,
	output logic busy,
	output logic conflict_th,
	// score board
	output oflow_pkg::sb_req_t sb_req,
	input oflow_pkg::cand_t cand,
	input logic [`PE_LEN-1:0] ptr,
	// flag vector
	input logic flag_rd,
	output logic [`ID_LEN-1:0] flag_addr,
	output logic flag_set,
	// look-up ram
	output logic [`ID_LEN-1:0] lut_addr,
	output logic lut_we,
	output oflow_pkg::lut_entry_t lut_wdata,
	input oflow_pkg::lut_entry_t lut_rdata
);

	oflow_pkg::cr_state_t state, next_state;
	logic [`ROW_LEN-1:0] cur_row; // row being settled
	logic [`ROW_LEN-1:0] ret_row; // highest row started, walk resumes after it
	logic [`ROW_LEN-1:0] disp_row; // owner that lost its id
	oflow_pkg::cand_t cand_q;
	logic [`ID_LEN-1:0] fresh_id;
	logic [`CONFLICT_CNT_LEN-1:0] conflict_cnt;
	logic displacing;
	logic below_th, last_pe, wins, take_fresh, conflict;

	// ---------------------------------------------------------------------------
	// decision terms
	// ---------------------------------------------------------------------------
	assign below_th = cand_q.score < score_th;
	assign last_pe = ptr == `PE_LEN'(`NUM_PE - 1); // no candidate left after this one
	assign wins = cand_q.score > lut_rdata.score; // tie keeps the first claimer
	assign conflict = (state == oflow_pkg::DECIDE) && !below_th && flag_rd;
	assign take_fresh = ((state == oflow_pkg::DECIDE) && (below_th || (conflict && !wins && last_pe)))
		|| ((state == oflow_pkg::DISPLACE) && last_pe);

	always_comb begin
		next_state = state;
		case (state)
			oflow_pkg::IDLE: if (start) next_state = oflow_pkg::FETCH;
			oflow_pkg::FETCH: next_state = oflow_pkg::WAIT_READ;
			oflow_pkg::WAIT_READ: next_state = oflow_pkg::LOOKUP;
			oflow_pkg::LOOKUP: next_state = oflow_pkg::DECIDE;
			oflow_pkg::DECIDE: begin
				if (below_th) next_state = oflow_pkg::NEXT_ROW; // fresh id
				else if (!flag_rd || wins) next_state = oflow_pkg::CLAIM;
				else if (last_pe) next_state = oflow_pkg::NEXT_ROW; // exhausted
				else next_state = oflow_pkg::FETCH; // retry next pe
			end
			oflow_pkg::CLAIM: next_state = displacing ? oflow_pkg::DISPLACE : oflow_pkg::NEXT_ROW;
			oflow_pkg::DISPLACE: next_state = last_pe ? oflow_pkg::NEXT_ROW : oflow_pkg::FETCH;
			oflow_pkg::NEXT_ROW: begin
				next_state = (ret_row == `ROW_LEN'(`NUM_ROWS - 1)) ? oflow_pkg::DONE : oflow_pkg::FETCH;
			end
			oflow_pkg::DONE: next_state = oflow_pkg::IDLE;
			default: next_state = oflow_pkg::IDLE;
		endcase
	end

	// score board request, pointer comes back for the same row
	assign sb_req.row = (state == oflow_pkg::DISPLACE) ? disp_row : cur_row;
	assign sb_req.pe = ptr;
	assign sb_req.ptr_we = (conflict && !wins && !last_pe)
		|| ((state == oflow_pkg::DISPLACE) && !last_pe);
	assign sb_req.ptr = ptr + 1'b1;
	assign sb_req.id_we = take_fresh || (state == oflow_pkg::CLAIM);
	assign sb_req.id = take_fresh ? fresh_id : cand_q.id;

	assign flag_addr = cand_q.id;
	assign flag_set = state == oflow_pkg::CLAIM;
	assign lut_addr = cand_q.id; // presented in LOOKUP, data in DECIDE
	assign lut_we = state == oflow_pkg::CLAIM;
	assign lut_wdata.row = cur_row;
	assign lut_wdata.score = cand_q.score;

	assign busy = state != oflow_pkg::IDLE;
	assign done = state == oflow_pkg::DONE; // last busy cycle

	// ---------------------------------------------------------------------------
	// state and counters
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_pkg::IDLE;
			cur_row <= '0;
			ret_row <= '0;
			fresh_id <= '0;
			conflict_cnt <= '0;
			conflict_th <= 1'b0;
			displacing <= 1'b0;
		end else begin
			state <= next_state;
			if (start && (state == oflow_pkg::IDLE)) begin
				cur_row <= '0;
				ret_row <= '0;
				fresh_id <= first_id;
				conflict_cnt <= '0;
				conflict_th <= 1'b0;
				displacing <= 1'b0;
			end
			if (take_fresh) fresh_id <= fresh_id + 1'b1;
			if (conflict && !conflict_th) begin
				conflict_cnt <= conflict_cnt + 1'b1;
				if (conflict_cnt == `CONFLICT_CNT_LEN'(`MAX_CONFLICTS_TH - 1)) conflict_th <= 1'b1;
			end
			if (state == oflow_pkg::DECIDE) displacing <= conflict && wins;
			if ((state == oflow_pkg::DISPLACE) && !last_pe) begin
				cur_row <= disp_row; // loser becomes current until it settles
			end
			if ((state == oflow_pkg::NEXT_ROW) && (next_state == oflow_pkg::FETCH)) begin
				cur_row <= ret_row + 1'b1;
				ret_row <= ret_row + 1'b1;
			end
		end
	end

	// candidate and owner capture
	always_ff @(posedge clk) begin
		if (state == oflow_pkg::WAIT_READ) cand_q <= cand;
		if (state == oflow_pkg::DECIDE) disp_row <= lut_rdata.row;
	end

endmodule

// File: design/oflow_conflict_resolve.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_conflict_resolve (
	input logic clk,
	input logic reset_N,
	input logic start,
	input logic [`SCORE_LEN-1:0] score_th,
	input logic [`ID_LEN-1:0] first_id,
	output logic done,
	output logic busy,
	output logic conflict_th,
	output oflow_pkg::sb_req_t sb_req,
	input oflow_pkg::cand_t cand,
	input logic [`PE_LEN-1:0] ptr
);

	logic [`LUT_DEPTH-1:0] flag_q; // valid bit per lut entry
	logic flag_rd, flag_set;
	logic [`ID_LEN-1:0] flag_addr, lut_addr;
	logic lut_we;
	oflow_pkg::lut_entry_t lut_wdata, lut_rdata;

	assign flag_rd = flag_q[flag_addr];

	// ---------------------------------------------------------------------------
	// flags, cleared per run so the lut ram itself never is
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			flag_q <= '0;
		end else if (start) begin
			flag_q <= '0;
		end else if (flag_set) begin
			flag_q[flag_addr] <= 1'b1;
		end
	end

	oflow_conflict_resolve_fsm u_fsm (
		.clk(clk),
		.reset_N(reset_N),
		.start(start),
		.score_th(score_th),
		.first_id(first_id),
		.done(done),
		.busy(busy),
		.conflict_th(conflict_th),
		.sb_req(sb_req),
		.cand(cand),
		.ptr(ptr),
		.flag_rd(flag_rd),
		.flag_addr(flag_addr),
		.flag_set(flag_set),
		.lut_addr(lut_addr),
		.lut_we(lut_we),
		.lut_wdata(lut_wdata),
		.lut_rdata(lut_rdata)
	);

	oflow_ram #(
		.T(oflow_pkg::lut_entry_t),
		.DEPTH(`LUT_DEPTH)
	) u_lut_ram (
		.clk(clk),
		.addr(lut_addr),
		.we(lut_we),
		.wdata(lut_wdata),
		.rdata(lut_rdata)
	);

endmodule

// File: design/oflow_apb_regs.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_apb_regs (
	input logic clk,
	input logic reset_N,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_LEN-1:0] paddr,
	input logic [`APB_DATA_LEN-1:0] pwdata,
	output logic [`APB_DATA_LEN-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	output logic [`SCORE_LEN-1:0] score_th,
	output logic [`ID_LEN-1:0] first_id,
	input logic done,
	input logic busy,
	input logic conflict_th,
	output logic [`ROW_LEN+`PE_LEN-1:0] sb_addr,
	output logic sb_we,
	output oflow_pkg::cand_t sb_wdata,
	input oflow_pkg::cand_t sb_rdata,
	output logic [`ROW_LEN-1:0] result_row,
	input oflow_pkg::result_t result
);

	logic access, wait_q, wr, mapped;
	logic hit_ctrl, hit_status, hit_th, hit_id, hit_cand, hit_result;
	logic [`APB_ADDR_LEN-1:0] cand_off, result_off;
	logic done_q; // sticky, cleared by start
	logic [`APB_DATA_LEN-1:0] rd_mux;

	// ---------------------------------------------------------------------------
	// one wait state on every transfer
	// ---------------------------------------------------------------------------
	assign access = psel && penable;
	assign pready = access && wait_q; // second access cycle
	assign wr = pready && pwrite;

	// address decode
	assign cand_off = paddr - `CAND_BASE;
	assign result_off = paddr - `RESULT_BASE;
	assign hit_ctrl = paddr == `REG_CTRL;
	assign hit_status = paddr == `REG_STATUS;
	assign hit_th = paddr == `REG_SCORE_TH;
	assign hit_id = paddr == `REG_FIRST_ID;
	assign hit_cand = (paddr >= `CAND_BASE) && (cand_off < `APB_ADDR_LEN'(4 * `NUM_ROWS * `NUM_PE));
	assign hit_result = (paddr >= `RESULT_BASE) && (result_off < `APB_ADDR_LEN'(4 * `NUM_ROWS));
	assign mapped = hit_ctrl || hit_status || hit_th || hit_id || hit_cand || hit_result;
	assign pslverr = pready && (!mapped || ((hit_cand || hit_result) && busy));

	// score board windows, ram read issued in the first access cycle
	assign sb_addr = cand_off[`ROW_LEN+`PE_LEN+1:2];
	assign sb_we = wr && hit_cand && !busy;
	assign sb_wdata = pwdata[$bits(oflow_pkg::cand_t)-1:0];
	assign result_row = result_off[`ROW_LEN+1:2];

	assign start = wr && hit_ctrl && pwdata[0] && !busy; // resolver sees it on the next edge

	always_comb begin
		rd_mux = '0;
		if (hit_status) rd_mux[2:0] = {busy, conflict_th, done_q};
		if (hit_th) rd_mux[`SCORE_LEN-1:0] = score_th;
		if (hit_id) rd_mux[`ID_LEN-1:0] = first_id;
		if (hit_cand && !busy) rd_mux[$bits(oflow_pkg::cand_t)-1:0] = sb_rdata;
		if (hit_result && !busy) rd_mux[$bits(oflow_pkg::result_t)-1:0] = result;
	end
	assign prdata = (pready && !pwrite) ? rd_mux : '0;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wait_q <= 1'b0;
			done_q <= 1'b0;
			score_th <= '0;
			first_id <= '0;
		end else begin
			wait_q <= access && !wait_q;
			if (start) done_q <= 1'b0;
			else if (done) done_q <= 1'b1;
			if (wr && hit_th) score_th <= pwdata[`SCORE_LEN-1:0];
			if (wr && hit_id) first_id <= pwdata[`ID_LEN-1:0];
		end
	end

endmodule

// File: design/oflow_tracker_top.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_tracker_top (
	input logic clk,
	input logic reset_N,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_LEN-1:0] paddr,
	input logic [`APB_DATA_LEN-1:0] pwdata,
	output logic [`APB_DATA_LEN-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// ---------------------------------------------------------------------------
	// control between registers and resolver
	// ---------------------------------------------------------------------------
	logic start, done, busy, conflict_th;
	logic [`SCORE_LEN-1:0] score_th;
	logic [`ID_LEN-1:0] first_id;

	// score board traffic
	logic [`ROW_LEN+`PE_LEN-1:0] sb_addr;
	logic sb_we;
	oflow_pkg::cand_t sb_wdata, sb_rdata, cr_cand;
	oflow_pkg::sb_req_t cr_req;
	logic [`PE_LEN-1:0] cr_ptr;
	logic [`ROW_LEN-1:0] result_row;
	oflow_pkg::result_t result;

	oflow_apb_regs u_apb_regs (
		.clk(clk), .reset_N(reset_N),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .score_th(score_th), .first_id(first_id),
		.done(done), .busy(busy), .conflict_th(conflict_th),
		.sb_addr(sb_addr), .sb_we(sb_we), .sb_wdata(sb_wdata), .sb_rdata(sb_rdata),
		.result_row(result_row), .result(result)
	);

	oflow_score_board u_score_board (
		.clk(clk), .reset_N(reset_N), .start(start), .busy(busy),
		.apb_addr(sb_addr), .apb_we(sb_we), .apb_wdata(sb_wdata), .apb_rdata(sb_rdata),
		.cr_req(cr_req), .cr_cand(cr_cand), .cr_ptr(cr_ptr),
		.result_row(result_row), .result(result)
	);

	oflow_conflict_resolve u_conflict_resolve (
		.clk(clk), .reset_N(reset_N), .start(start),
		.score_th(score_th), .first_id(first_id),
		.done(done), .busy(busy), .conflict_th(conflict_th),
		.sb_req(cr_req), .cand(cr_cand), .ptr(cr_ptr)
	);

endmodule

// File: sim/oflow_tb_assertions.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_tb_assertions (
	input logic clk,
	input logic reset_N,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic [`APB_ADDR_LEN-1:0] paddr,
	input logic done,
	input logic busy,
	input oflow_pkg::sb_req_t cr_req
);

	int failures = 0; // failed assertions so far
	logic [`ID_LEN-1:0] id_shadow [`NUM_ROWS]; // last id written per row
	logic ids_distinct;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			id_shadow <= '{default: '0};
		end else if (cr_req.id_we) begin
			id_shadow[cr_req.row] <= cr_req.id;
		end
	end

	// every row is settled by done so ids must differ pairwise
	always_comb begin
		ids_distinct = 1'b1;
		for (int i = 0; i < `NUM_ROWS; i++) begin
			for (int j = i + 1; j < `NUM_ROWS; j++) begin
				if (id_shadow[i] == id_shadow[j]) ids_distinct = 1'b0;
			end
		end
	end

	// ---------------------------------------------------------------------------
	// apb protocol
	// ---------------------------------------------------------------------------
	penable_follows_psel: assert property (@(posedge clk) disable iff (!reset_N)
		psel && !penable |=> psel && penable)
		else begin
			$error("setup phase not followed by access phase");
			failures++;
		end

	penable_needs_psel: assert property (@(posedge clk) disable iff (!reset_N)
		penable |-> psel)
		else begin
			$error("penable high without psel");
			failures++;
		end

	paddr_stable: assert property (@(posedge clk) disable iff (!reset_N)
		psel && penable && !pready |=> $stable(paddr))
		else begin
			$error("paddr changed during wait state");
			failures++;
		end

	// resolver, done is a single pulse in the last busy cycle
	done_in_busy: assert property (@(posedge clk) disable iff (!reset_N)
		done |-> busy ##1 (!busy && !done))
		else begin
			$error("done pulse outside busy or busy still high after done");
			failures++;
		end

	unique_ids: assert property (@(posedge clk) disable iff (!reset_N)
		done |-> ids_distinct)
		else begin
			$error("two rows hold the same id at the end of a run");
			failures++;
		end

endmodule

bind oflow_tracker_top oflow_tb_assertions u_tb_assertions (
	.clk(clk), .reset_N(reset_N), .psel(psel), .penable(penable), .pready(pready),
	.paddr(paddr), .done(done), .busy(busy), .cr_req(cr_req)
);

// File: sim/oflow_tb.sv
`timescale 1ns/100ps
`include "oflow_defs.svh"

module oflow_tb;

	localparam int RUN_CYCLES = 500; // load, run and readback of one frame
	localparam int TEST_CYCLES = 16 + 40 + 8 * RUN_CYCLES; // reset, registers, eight frames
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
	localparam logic [`APB_ADDR_LEN-1:0] UNMAPPED_ADDR = 12'h010;

	logic clk;
	logic reset_N;
	logic psel, penable, pwrite;
	logic [`APB_ADDR_LEN-1:0] paddr;
	logic [`APB_DATA_LEN-1:0] pwdata, prdata;
	logic pready, pslverr;

	int checks, errors, cycle_cnt;
	logic [31:0] lfsr_q;

	// testbench copy of the frame and the model's answer
	oflow_pkg::cand_t frame [`NUM_ROWS][`NUM_PE];
	logic [`SCORE_LEN-1:0] frame_th;
	logic [`ID_LEN-1:0] frame_first_id;
	logic [`ID_LEN-1:0] exp_id [`NUM_ROWS];
	logic [`PE_LEN-1:0] exp_ptr [`NUM_ROWS];
	int exp_conflicts;

	oflow_tracker_top u_oflow_tracker_top (
		.clk(clk), .reset_N(reset_N),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #50 clk = ~clk; // 100 ns period

	// watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%s finished with %0d errors", name, errors - err_before);
	endtask

	// ---------------------------------------------------------------------------
	// apb driver with one setup cycle and exactly one wait state
	// ---------------------------------------------------------------------------
	task automatic apb_transfer(input logic write, input logic [`APB_ADDR_LEN-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#10;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#10;
		penable = 1'b1;
		@(negedge clk); // first access cycle
		check_value(pready, 1'b0, $sformatf("pready in first access cycle at %0h", addr));
		@(negedge clk);
		check_value(pready, 1'b1, $sformatf("pready in second access cycle at %0h", addr));
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#10;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_ADDR_LEN-1:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [`APB_ADDR_LEN-1:0] addr, output logic [31:0] data,
		output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic write_ok(input logic [`APB_ADDR_LEN-1:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check_value(err, 1'b0, $sformatf("pslverr on write to %0h", addr));
	endtask

	task automatic read_ok(input logic [`APB_ADDR_LEN-1:0] addr, output logic [31:0] data);
		logic err;
		apb_read(addr, data, err);
		check_value(err, 1'b0, $sformatf("pslverr on read from %0h", addr));
	endtask

	// ---------------------------------------------------------------------------
	// frame setup and run control
	// ---------------------------------------------------------------------------
	function automatic void fill_unique(input logic [`SCORE_LEN-1:0] score);
		for (int r = 0; r < `NUM_ROWS; r++) begin
			for (int p = 0; p < `NUM_PE; p++) begin
				frame[r][p].score = score;
				frame[r][p].id = `ID_LEN'(r * `NUM_PE + p);
			end
		end
	endfunction

	function automatic void set_cand(input int r, input int p, input int score, input int id);
		frame[r][p].score = `SCORE_LEN'(score);
		frame[r][p].id = `ID_LEN'(id);
	endfunction

	// shared ids, a tie, a displacement chain and an exhausted row
	function automatic void build_conflict_frame();
		fill_unique(8'd100);
		set_cand(0, 0, 100, 5);
		set_cand(0, 1, 90, 6);
		set_cand(0, 2, 80, 9);
		set_cand(1, 0, 150, 5); // displaces row 0
		set_cand(2, 0, 120, 6); // displaces row 0 again
		set_cand(2, 1, 110, 21);
		set_cand(3, 0, 70, 9); // loses every candidate
		set_cand(3, 1, 60, 5);
		set_cand(3, 2, 60, 6);
		set_cand(3, 3, 60, 9);
		set_cand(4, 0, 80, 9); // tie with row 0
		set_cand(4, 1, 50, 20);
		set_cand(4, 2, 150, 6);
		set_cand(5, 0, 200, 20); // chain through rows 4 and 2
	endfunction

	// every candidate asks for one id with equal scores, so the limit is crossed
	function automatic void build_same_id_frame();
		fill_unique(8'd100);
		for (int r = 0; r < `NUM_ROWS; r++) begin
			for (int p = 0; p < `NUM_PE; p++) begin
				frame[r][p].id = `ID_LEN'(3);
			end
		end
	endfunction

	task automatic load_frame(input logic [`SCORE_LEN-1:0] th, input logic [`ID_LEN-1:0] first_id);
		frame_th = th;
		frame_first_id = first_id;
		for (int r = 0; r < `NUM_ROWS; r++) begin
			for (int p = 0; p < `NUM_PE; p++) begin
				write_ok(`CAND_BASE + `APB_ADDR_LEN'(4 * (r * `NUM_PE + p)), 32'(frame[r][p]));
			end
		end
		write_ok(`REG_SCORE_TH, 32'(th));
		write_ok(`REG_FIRST_ID, 32'(first_id));
	endtask

	task automatic start_run();
		write_ok(`REG_CTRL, 32'h1);
	endtask

	task automatic wait_done();
		logic [31:0] status;
		status = '0;
		while (!status[0]) begin
			read_ok(`REG_STATUS, status);
		end
	endtask

	task automatic run_and_wait();
		start_run();
		wait_done();
	endtask

	task automatic read_result(input int r, output logic [`ID_LEN-1:0] id,
		output logic [`PE_LEN-1:0] ptr);
		logic [31:0] data;
		read_ok(`RESULT_BASE + `APB_ADDR_LEN'(4 * r), data);
		id = data[`ID_LEN+`PE_LEN-1:`PE_LEN];
		ptr = data[`PE_LEN-1:0];
	endtask

	// ---------------------------------------------------------------------------
	// reference model of the resolver rule
	// ---------------------------------------------------------------------------
	function automatic void resolve_model();
		logic lut_valid [`LUT_DEPTH];
		int lut_row [`LUT_DEPTH];
		int lut_score [`LUT_DEPTH];
		logic [`ID_LEN-1:0] fresh;
		oflow_pkg::cand_t c;
		int cur, loser;
		bit settled;
		lut_valid = '{default: 1'b0};
		exp_ptr = '{default: '0};
		fresh = frame_first_id;
		exp_conflicts = 0;
		for (int row = 0; row < `NUM_ROWS; row++) begin
			cur = row;
			settled = 1'b0;
			while (!settled) begin
				c = frame[cur][exp_ptr[cur]];
				if (c.score < frame_th) begin
					exp_id[cur] = fresh++; // weak match
					settled = 1'b1;
				end else if (!lut_valid[c.id]) begin
					lut_valid[c.id] = 1'b1;
					lut_row[c.id] = cur;
					lut_score[c.id] = c.score;
					exp_id[cur] = c.id;
					settled = 1'b1;
				end else begin
					exp_conflicts++;
					if (c.score > lut_score[c.id]) begin
						loser = lut_row[c.id];
						lut_row[c.id] = cur;
						lut_score[c.id] = c.score;
						exp_id[cur] = c.id;
						if (exp_ptr[loser] == `NUM_PE - 1) begin
							exp_id[loser] = fresh++;
							settled = 1'b1;
						end else begin
							exp_ptr[loser]++;
							cur = loser; // loser settles before the walk goes on
						end
					end else if (exp_ptr[cur] == `NUM_PE - 1) begin
						exp_id[cur] = fresh++; // out of candidates
						settled = 1'b1;
					end else begin
						exp_ptr[cur]++;
					end
				end
			end
		end
	endfunction

	task automatic check_results(input string name);
		logic [`ID_LEN-1:0] id;
		logic [`PE_LEN-1:0] ptr;
		logic [31:0] status;
		resolve_model();
		for (int r = 0; r < `NUM_ROWS; r++) begin
			read_result(r, id, ptr);
			check_value(id, exp_id[r], $sformatf("%s row %0d id", name, r));
			check_value(ptr, exp_ptr[r], $sformatf("%s row %0d pointer", name, r));
		end
		read_ok(`REG_STATUS, status);
		check_value(status, 32'({1'b0, exp_conflicts >= `MAX_CONFLICTS_TH, 1'b1}),
			$sformatf("%s status", name));
	endtask

	// ---------------------------------------------------------------------------
	// directed tests
	// ---------------------------------------------------------------------------
	task automatic regs_after_reset();
		int err_before;
		logic [31:0] data;
		logic err;
		err_before = errors;
		read_ok(`REG_STATUS, data);
		check_value(data, 32'h0, "status after reset");
		write_ok(`REG_SCORE_TH, 32'h5A);
		write_ok(`REG_FIRST_ID, 32'h2B);
		read_ok(`REG_SCORE_TH, data);
		check_value(data, 32'h5A, "score_th readback");
		read_ok(`REG_FIRST_ID, data);
		check_value(data, 32'h2B, "first_id readback");
		apb_read(UNMAPPED_ADDR, data, err);
		check_value(err, 1'b1, "pslverr on unmapped address");
		report_test("reset and registers", err_before);
	endtask

	task automatic frame_without_conflicts();
		int err_before;
		logic [`ID_LEN-1:0] id;
		logic [`PE_LEN-1:0] ptr;
		err_before = errors;
		fill_unique(8'd200);
		load_frame(8'd10, 6'd48);
		run_and_wait();
		for (int r = 0; r < `NUM_ROWS; r++) begin
			read_result(r, id, ptr);
			check_value(id, frame[r][0].id, $sformatf("row %0d first candidate id", r));
			check_value(ptr, 0, $sformatf("row %0d pointer", r));
		end
		check_results("no conflicts");
		report_test("no conflicts", err_before);
	endtask

	task automatic threshold_fresh_ids();
		int err_before;
		logic [`ID_LEN-1:0] id;
		logic [`PE_LEN-1:0] ptr;
		err_before = errors;
		fill_unique(8'd150);
		for (int r = 0; r < `NUM_ROWS; r += 2) begin
			frame[r][0].score = 8'd50; // even rows below threshold
		end
		load_frame(8'd100, 6'd40);
		run_and_wait();
		for (int r = 0; r < `NUM_ROWS; r++) begin
			read_result(r, id, ptr);
			check_value(id, (r % 2 == 0) ? 40 + r / 2 : frame[r][0].id,
				$sformatf("row %0d threshold id", r));
		end
		report_test("threshold", err_before);
	endtask

	task automatic conflict_resolution();
		int err_before;
		err_before = errors;
		build_conflict_frame();
		load_frame(8'd40, 6'd48);
		run_and_wait();
		check_results("conflicts");
		build_same_id_frame();
		load_frame(8'd40, 6'd48);
		run_and_wait();
		check_results("same id");
		report_test("conflicts and displacement", err_before);
	endtask

	task automatic random_frames();
		int err_before;
		err_before = errors;
		for (int f = 0; f < 3; f++) begin
			for (int r = 0; r < `NUM_ROWS; r++) begin
				for (int p = 0; p < `NUM_PE; p++) begin
					frame[r][p].score = `SCORE_LEN'(rand_bits(`SCORE_LEN));
					frame[r][p].id = `ID_LEN'(rand_bits(3 + f)); // narrow ids give many clashes
				end
			end
			load_frame(8'd32, 6'd48);
			run_and_wait();
			check_results($sformatf("random frame %0d", f));
		end
		report_test("random frames", err_before);
	endtask

	task automatic busy_access_errors();
		int err_before;
		logic [31:0] data;
		logic err;
		err_before = errors;
		build_conflict_frame();
		load_frame(8'd40, 6'd48);
		start_run();
		read_ok(`REG_STATUS, data);
		check_value(data[2], 1'b1, "busy during run");
		apb_write(`CAND_BASE, 32'h3FFF, err);
		check_value(err, 1'b1, "pslverr on candidate write while busy");
		apb_read(`CAND_BASE + 12'h004, data, err);
		check_value(err, 1'b1, "pslverr on candidate read while busy");
		check_value(data, 32'h0, "candidate read data while busy");
		apb_read(`RESULT_BASE, data, err);
		check_value(err, 1'b1, "pslverr on result read while busy");
		check_value(data, 32'h0, "result read data while busy");
		wait_done();
		check_results("busy errors");
		read_ok(`CAND_BASE, data);
		check_value(data, 32'(frame[0][0]), "candidate after rejected write");
		report_test("busy errors", err_before);
	endtask

	initial begin
		clk = 1'b0;
		reset_N = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		cycle_cnt = 0;
		lfsr_q = 32'h391;
		repeat (16) @(posedge clk);
		#10;
		reset_N = 1'b1;

		regs_after_reset();
		frame_without_conflicts();
		threshold_fresh_ids();
		conflict_resolution();
		random_frames();
		busy_access_errors();

		errors = errors + u_oflow_tracker_top.u_tb_assertions.failures;
		$display("%0d checks, %0d errors, %0d of them from bound assertions", checks, errors,
			u_oflow_tracker_top.u_tb_assertions.failures);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+design
design/oflow_pkg.sv
design/oflow_ram.sv
design/oflow_score_board.sv
design/oflow_conflict_resolve_fsm.sv
design/oflow_conflict_resolve.sv
design/oflow_apb_regs.sv
design/oflow_tracker_top.sv
sim/oflow_tb_assertions.sv
sim/oflow_tb.sv
